//--- correction_fifo.sv
`timescale 1ns/10ps
`include "decoder_defines.svh"

module correction_fifo #(
    parameter int WIDTH = `CORRECTION_WIDTH,
    parameter int DEPTH = `OUTPUT_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    logic [WIDTH-1:0]    mem [0:DEPTH-1];
    logic [ADDR_WIDTH:0] wr_ptr;   // extra bit tells full from empty
    logic [ADDR_WIDTH:0] rd_ptr;

    assign out_valid = (wr_ptr != rd_ptr);
    assign in_ready  = !((wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH])
                         && (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]));
    assign out_data  = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid && in_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_valid && out_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- decode_progress_if.sv
`timescale 1ns/10ps
`include "decoder_defines.svh"

interface decode_progress_if import decoder_pkg::*; ();

    decoder_stage_t              stage;
    logic                        decode_start;    // header accepted, first block
    logic [`ITERATION_WIDTH-1:0] iteration_count;
    logic [15:0]                 cycle_count;

    modport sequencer (output stage, output decode_start);

    modport statistics (
        input  stage,
        input  decode_start,
        output iteration_count,
        output cycle_count
    );

    modport streamer (input stage, input iteration_count, input cycle_count);

endinterface

//--- decode_statistics.sv
`timescale 1ns/10ps
`include "decoder_defines.svh"

module decode_statistics import decoder_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    decode_progress_if.statistics progress,
    output ctrl_msg_u             ctrl_tx_data,
    output logic                  ctrl_tx_valid
);

    decoder_stage_t              stage_previous;
    logic [`ITERATION_WIDTH-1:0] iteration_count;
    logic [15:0]                 cycle_count;
    logic                        result_sent;
    logic                        counting;

    assign counting = progress.stage inside {STAGE_GROW, STAGE_MERGE, STAGE_PEELING};

    assign progress.iteration_count = iteration_count;
    assign progress.cycle_count     = cycle_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_previous  <= STAGE_IDLE;
            iteration_count <= '0;
            cycle_count     <= '0;
            result_sent     <= 1'b0;
        end else begin
            stage_previous <= progress.stage;

            if (progress.stage == STAGE_MEASUREMENT_LOADING) begin
                iteration_count <= '0;
            end else if (progress.stage == STAGE_GROW && stage_previous != STAGE_GROW) begin
                iteration_count <= iteration_count + 1'b1;
            end

            // starts at 1 so the report shows the current cycle
            if (progress.decode_start) begin
                cycle_count <= 16'd1;
            end else if (counting) begin
                cycle_count <= cycle_count + 16'd1;
            end

            if (progress.stage == STAGE_RESULT_VALID) begin
                result_sent <= 1'b1;
            end else if (progress.stage == STAGE_IDLE) begin
                result_sent <= 1'b0;
            end
        end
    end

    assign ctrl_tx_valid = (progress.stage == STAGE_RESULT_VALID) && !result_sent;

    always_comb begin
        ctrl_tx_data                    = '0;
        ctrl_tx_data.report.iteration   = iteration_count;
        ctrl_tx_data.report.cycle_count = cycle_count;
    end

endmodule

//--- decoder_controller.f
+incdir+.
decoder_pkg.sv
decode_progress_if.sv
correction_fifo.sv
stage_sequencer.sv
decode_statistics.sv
result_streamer.sv
decoder_controller.sv
tb_decoder_controller.sv

//--- decoder_controller.sv
`timescale 1ns/10ps
`include "decoder_defines.svh"

module decoder_controller import decoder_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [7:0]                    input_data,
    input  logic                          input_valid,
    output logic                          input_ready,

    output logic [7:0]                    output_data,
    output logic                          output_valid,
    input  logic                          output_ready,

    input  logic [`CTRL_WIDTH-1:0]        ctrl_rx_data,
    input  logic                          ctrl_rx_valid,
    output logic                          ctrl_rx_ready,

    output logic [`CTRL_WIDTH-1:0]        ctrl_tx_data,
    output logic                          ctrl_tx_valid,

    input  logic [`PU_COUNT-1:0]          busy_pe,
    input  logic [`PU_COUNT-1:0]          odd_clusters_pe,
    output logic [`MEASUREMENT_WIDTH-1:0] measurements,
    input  logic [`CORRECTION_WIDTH-1:0]  correction,
    output decoder_stage_t                global_stage,
    output logic                          reset_all_edges
);

    decode_progress_if progress ();

    assign global_stage = progress.stage;

    stage_sequencer u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .ctrl_rx_data    (ctrl_rx_data),
        .ctrl_rx_valid   (ctrl_rx_valid),
        .ctrl_rx_ready   (ctrl_rx_ready),
        .input_data      (input_data),
        .input_valid     (input_valid),
        .input_ready     (input_ready),
        .busy_pe         (busy_pe),
        .odd_clusters_pe (odd_clusters_pe),
        .measurements    (measurements),
        .reset_all_edges (reset_all_edges),
        .progress        (progress.sequencer)
    );

    decode_statistics u_statistics (
        .clk           (clk),
        .reset         (reset),
        .progress      (progress.statistics),
        .ctrl_tx_data  (ctrl_tx_data),
        .ctrl_tx_valid (ctrl_tx_valid)
    );

    result_streamer u_streamer (
        .clk          (clk),
        .reset        (reset),
        .progress     (progress.streamer),
        .correction   (correction),
        .output_data  (output_data),
        .output_valid (output_valid),
        .output_ready (output_ready)
    );

endmodule

//--- decoder_defines.svh
`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

// grid dimensions
`define GRID_WIDTH_X 4
`define GRID_WIDTH_Z 1
`define GRID_WIDTH_U 3

`define PU_COUNT_PER_ROUND (`GRID_WIDTH_X * `GRID_WIDTH_Z)
`define PU_COUNT (`PU_COUNT_PER_ROUND * `GRID_WIDTH_U)

`define MEASUREMENT_WIDTH 8   // per round, whole bytes
`define CORRECTION_WIDTH 11   // ns + ew + ud edges per round
`define CORRECTION_BYTES 2

`define MAXIMUM_DELAY 3       // merge settle cycles
`define ITERATION_WIDTH 8
`define OUTPUT_FIFO_DEPTH 128
`define CTRL_WIDTH 64
`define HEADER_BYTES 3

`endif

//--- decoder_pkg.sv
`include "decoder_defines.svh"

package decoder_pkg;

    typedef enum logic [3:0] {
        STAGE_IDLE                  = 4'd0,
        STAGE_GROW                  = 4'd2,
        STAGE_MERGE                 = 4'd3,
        STAGE_PEELING               = 4'd4,
        STAGE_RESULT_VALID          = 4'd5,
        STAGE_PARAMETERS_LOADING    = 4'd6,
        STAGE_MEASUREMENT_PREPARING = 4'd7,
        STAGE_MEASUREMENT_LOADING   = 4'd8
    } decoder_stage_t;

    // control message headers
    localparam logic [7:0] START_DECODING_MSG      = 8'h01;
    localparam logic [7:0] MEASUREMENT_DATA_HEADER = 8'h02;
    localparam logic [7:0] MOVE_TO_STAGE           = 8'h03;

    typedef struct packed {
        logic [15:0] unused_hi;
        logic [7:0]  header;
        logic [37:0] unused_lo;
        logic [1:0]  flags;       // bit 0 selects the first measurement block
    } ctrl_cmd_t;

    typedef struct packed {
        logic [15:0]                 unused_hi;
        logic [`ITERATION_WIDTH-1:0] iteration;
        logic [15:0]                 cycle_count;
        logic [23:0]                 zero;
    } ctrl_report_t;

    // one word, decoded as an incoming command or an outgoing report
    typedef union packed {
        ctrl_cmd_t    cmd;
        ctrl_report_t report;
    } ctrl_msg_u;

endpackage

//--- result_streamer.sv
`timescale 1ns/10ps
`include "decoder_defines.svh"

module result_streamer import decoder_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    decode_progress_if.streamer          progress,
    input  logic [`CORRECTION_WIDTH-1:0] correction,
    output logic [7:0]                   output_data,
    output logic                         output_valid,
    input  logic                         output_ready
);

    localparam int WORD_BITS    = `CORRECTION_BYTES * 8;
    localparam int PAD          = WORD_BITS - `CORRECTION_WIDTH;
    localparam int STREAM_BYTES = `HEADER_BYTES + `GRID_WIDTH_U * `CORRECTION_BYTES;
    localparam int COUNT_WIDTH  = $clog2(STREAM_BYTES);
    localparam int SEL_WIDTH    = (`CORRECTION_BYTES > 1) ? $clog2(`CORRECTION_BYTES) : 1;
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(STREAM_BYTES - 1);
    localparam logic [SEL_WIDTH-1:0]   LAST_SEL   = SEL_WIDTH'(`CORRECTION_BYTES - 1);

    logic                         capture;
    logic [`CORRECTION_WIDTH-1:0] fifo_out_data;
    logic                         fifo_out_valid;
    logic                         fifo_out_ready;
    logic [WORD_BITS-1:0]         word_buf;
    logic                         word_valid;
    logic [SEL_WIDTH-1:0]         byte_sel;
    logic [COUNT_WIDTH-1:0]       byte_count;
    logic                         header_phase;
    logic                         byte_taken;

    correction_fifo #(
        .WIDTH (`CORRECTION_WIDTH),
        .DEPTH (`OUTPUT_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (correction),
        .in_valid  (capture),
        .in_ready  (),
        .out_data  (fifo_out_data),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready)
    );

    assign fifo_out_ready = !word_valid;   // refill once the last byte is gone
    assign header_phase   = (byte_count < COUNT_WIDTH'(`HEADER_BYTES));
    assign output_valid   = word_valid;    // header waits for the first word too
    assign byte_taken     = output_valid && output_ready;

    always_comb begin
        case (byte_count)
            0:       output_data = progress.iteration_count;
            1:       output_data = progress.cycle_count[15:8];
            2:       output_data = progress.cycle_count[7:0];
            default: output_data = word_buf[byte_sel*8 +: 8];
        endcase
    end

    always_ff @(posedge clk) begin
        if (fifo_out_valid && fifo_out_ready) begin
            word_buf <= {{PAD{1'b0}}, fifo_out_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            capture    <= 1'b0;
            word_valid <= 1'b0;
            byte_sel   <= '0;
            byte_count <= '0;
        end else begin
            capture <= (progress.stage == STAGE_RESULT_VALID);   // correction lags a cycle

            if (fifo_out_valid && fifo_out_ready) begin
                word_valid <= 1'b1;
                byte_sel   <= '0;
            end else if (byte_taken && !header_phase) begin
                byte_sel <= byte_sel + 1'b1;
                if (byte_sel == LAST_SEL) begin
                    word_valid <= 1'b0;
                end
            end

            if (byte_taken) begin
                byte_count <= (byte_count == LAST_COUNT) ? '0 : byte_count + 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --top-module tb_decoder_controller -f decoder_controller.f \
    -o tb_decoder_controller || exit 1
./obj_dir/tb_decoder_controller > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1

//--- stage_sequencer.sv
`timescale 1ns/10ps
`include "decoder_defines.svh"

module stage_sequencer import decoder_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  ctrl_msg_u                     ctrl_rx_data,
    input  logic                          ctrl_rx_valid,
    output logic                          ctrl_rx_ready,
    input  logic [7:0]                    input_data,
    input  logic                          input_valid,
    output logic                          input_ready,
    input  logic [`PU_COUNT-1:0]          busy_pe,
    input  logic [`PU_COUNT-1:0]          odd_clusters_pe,
    output logic [`MEASUREMENT_WIDTH-1:0] measurements,
    output logic                          reset_all_edges,
    decode_progress_if.sequencer          progress
);

    localparam int ROUND_WIDTH = $clog2(`GRID_WIDTH_U + 1);
    localparam int DELAY_WIDTH = $clog2(`MAXIMUM_DELAY + 1);
    localparam logic [ROUND_WIDTH-1:0] ROUNDS = ROUND_WIDTH'(`GRID_WIDTH_U);
    localparam logic [DELAY_WIDTH-1:0] SETTLE = DELAY_WIDTH'(`MAXIMUM_DELAY);

    decoder_stage_t                stage;
    logic                          busy;
    logic                          odd_clusters;
    logic [ROUND_WIDTH-1:0]        round_count;   // measurement rounds, then result rounds
    logic [DELAY_WIDTH-1:0]        delay_count;
    logic                          ctrl_accept;
    logic                          byte_accept;
    logic [`MEASUREMENT_WIDTH+7:0] shifted;

    // pe flags lag one cycle
    always_ff @(posedge clk) begin
        busy         <= |busy_pe;
        odd_clusters <= |odd_clusters_pe;
    end

    assign ctrl_rx_ready   = (stage == STAGE_IDLE);
    assign input_ready     = (stage == STAGE_MEASUREMENT_PREPARING);
    assign ctrl_accept     = ctrl_rx_valid && ctrl_rx_ready;
    assign byte_accept     = input_valid && input_ready;
    assign reset_all_edges = (stage == STAGE_MEASUREMENT_LOADING);

    assign progress.stage        = stage;
    assign progress.decode_start = ctrl_accept && !ctrl_rx_data.cmd.flags[0]
                                   && (ctrl_rx_data.cmd.header == MEASUREMENT_DATA_HEADER);

    // new byte enters at the top
    assign shifted = {input_data, measurements} >> 8;

    always_ff @(posedge clk) begin
        if (byte_accept) begin
            measurements <= shifted[`MEASUREMENT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage       <= STAGE_IDLE;
            round_count <= '0;
            delay_count <= '0;
        end else begin
            case (stage)
                STAGE_IDLE: begin
                    round_count <= '0;
                    if (ctrl_accept) begin
                        case (ctrl_rx_data.cmd.header)
                            START_DECODING_MSG:      stage <= STAGE_PARAMETERS_LOADING;
                            MEASUREMENT_DATA_HEADER: stage <= STAGE_MEASUREMENT_PREPARING;
                            MOVE_TO_STAGE:           stage <= STAGE_GROW;
                            default:                 stage <= STAGE_IDLE;
                        endcase
                    end
                end
                STAGE_PARAMETERS_LOADING: stage <= STAGE_IDLE;
                STAGE_MEASUREMENT_PREPARING: begin
                    if (byte_accept) begin   // one byte per round
                        round_count <= round_count + 1'b1;
                        stage       <= STAGE_MEASUREMENT_LOADING;
                    end
                end
                STAGE_MEASUREMENT_LOADING: begin
                    if (round_count < ROUNDS) begin
                        stage <= STAGE_MEASUREMENT_PREPARING;
                    end else begin
                        round_count <= '0;
                        stage       <= STAGE_GROW;
                    end
                end
                STAGE_GROW: begin
                    delay_count <= '0;
                    stage       <= STAGE_MERGE;
                end
                STAGE_MERGE: begin
                    if (delay_count < SETTLE) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!busy) begin
                        stage <= odd_clusters ? STAGE_GROW : STAGE_PEELING;
                    end
                end
                STAGE_PEELING: stage <= STAGE_RESULT_VALID;
                STAGE_RESULT_VALID: begin   // one cycle per round of corrections
                    if (round_count == ROUNDS - 1'b1) begin
                        round_count <= '0;
                        stage       <= STAGE_IDLE;
                    end else begin
                        round_count <= round_count + 1'b1;
                    end
                end
                default: stage <= STAGE_IDLE;
            endcase
        end
    end

endmodule

//--- tb_decoder_controller.sv
`timescale 1ns/10ps
`include "decoder_defines.svh"

module tb_decoder_controller import decoder_pkg::*; ();

    localparam int PU = `PU_COUNT;
    localparam int CW = `CORRECTION_WIDTH;
    localparam int MW = `MEASUREMENT_WIDTH;
    localparam int STREAM_BYTES = `HEADER_BYTES + `GRID_WIDTH_U * `CORRECTION_BYTES;
    localparam int WATCHDOG_CYCLES = 5000;   // several times the longest directed run

    logic           clk = 1'b0;
    logic           reset;
    logic [7:0]     input_data;
    logic           input_valid;
    logic           input_ready;
    logic [7:0]     output_data;
    logic           output_valid;
    logic           output_ready;
    ctrl_msg_u      ctrl_rx_data;
    logic           ctrl_rx_valid;
    logic           ctrl_rx_ready;
    ctrl_msg_u      ctrl_tx_data;
    logic           ctrl_tx_valid;
    logic [PU-1:0]  busy_pe = '0;
    logic [PU-1:0]  odd_clusters_pe = '0;
    logic [MW-1:0]  measurements;
    logic [CW-1:0]  correction = '0;
    decoder_stage_t global_stage;
    logic           reset_all_edges;

    // pe script and expected statistics
    int             odd_target;
    int             busy_extra;
    int             merges_done = 0;
    int             busy_left = 0;
    decoder_stage_t prev_stage = STAGE_IDLE;
    logic [7:0]     exp_iteration = '0;
    logic [15:0]    exp_cycles = '0;
    logic [CW-1:0]  corr_words [0:15];
    int             corr_count = 0;
    ctrl_msg_u      report_expected;
    int             errors = 0;
    int             checks = 0;
    int             tests_run = 0;

    decoder_controller dut (.*);

    always #4 clk = ~clk;

    // processing elements and correction source
    always @(posedge clk) begin
        logic [CW-1:0] word;
        prev_stage <= global_stage;
        if (global_stage == STAGE_IDLE) begin
            merges_done <= 0;
        end else if (prev_stage == STAGE_MERGE && global_stage != STAGE_MERGE) begin
            merges_done <= merges_done + 1;
        end
        if (global_stage == STAGE_GROW) begin
            busy_left <= `MAXIMUM_DELAY + busy_extra;
        end else if (busy_left > 0) begin
            busy_left <= busy_left - 1;
        end
        busy_pe <= (busy_left > 0) ? PU'(1) << (busy_left % PU) : '0;
        odd_clusters_pe <= (merges_done < odd_target) ? PU'(1) << (merges_done % PU) : '0;
        if (global_stage == STAGE_RESULT_VALID) begin   // captured on the next cycle
            word = CW'($urandom);
            correction             <= word;
            corr_words[corr_count] <= word;
            corr_count             <= corr_count + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, stage %s", WATCHDOG_CYCLES,
                 global_stage.name());
        $display("Test failed");
        $finish;
    end

    task automatic check_stage(input decoder_stage_t got, input decoder_stage_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: global_stage = %s, expected %s", $time, got.name(),
                     expected.name());
        end
    endtask

    task automatic check_report(input ctrl_msg_u got, input ctrl_msg_u expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: ctrl_tx_data = %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_measurements(input logic [MW-1:0] got, input logic [MW-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: measurements = %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic finish_test(input string label, input int errors_before);
        tests_run++;
        $display("%-32s %s", label, (errors == errors_before) ? "ok" : "with errors");
    endtask

    task automatic send_ctrl(input logic [7:0] header);
        ctrl_msg_u msg;
        msg            = '0;
        msg.cmd.header = header;
        ctrl_rx_data  <= msg;
        ctrl_rx_valid <= 1'b1;
        @(posedge clk);
        while (!ctrl_rx_ready) @(posedge clk);
        ctrl_rx_valid <= 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] value);
        input_data  <= value;
        input_valid <= 1'b1;
        @(posedge clk);
        while (!input_ready) @(posedge clk);
        input_valid <= 1'b0;
    endtask

    task automatic test_reset();
        int errors_before;
        errors_before = errors;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_stage(global_stage, STAGE_IDLE);
        check_flag("ctrl_rx_ready", ctrl_rx_ready, 1'b1);
        check_flag("input_ready", input_ready, 1'b0);
        check_flag("ctrl_tx_valid", ctrl_tx_valid, 1'b0);
        check_flag("output_valid", output_valid, 1'b0);
        check_flag("reset_all_edges", reset_all_edges, 1'b0);
        finish_test("reset state", errors_before);
    endtask

    task automatic test_load();
        int         errors_before;
        logic [7:0] value;
        errors_before = errors;
        send_ctrl(START_DECODING_MSG);
        @(posedge clk);
        check_stage(global_stage, STAGE_PARAMETERS_LOADING);
        @(posedge clk);
        check_stage(global_stage, STAGE_IDLE);
        send_ctrl(MEASUREMENT_DATA_HEADER);
        exp_iteration = '0;      // cleared while loading
        exp_cycles    = 16'd1;   // header restarts the count
        for (int r = 0; r < `GRID_WIDTH_U; r++) begin
            value = 8'($urandom);
            send_byte(value);
            @(posedge clk);
            check_stage(global_stage, STAGE_MEASUREMENT_LOADING);
            check_flag("reset_all_edges", reset_all_edges, 1'b1);
            check_measurements(measurements, value);
            @(posedge clk);
            check_flag("reset_all_edges", reset_all_edges, 1'b0);
            check_stage(global_stage, (r == `GRID_WIDTH_U - 1) ? STAGE_GROW
                                                               : STAGE_MEASUREMENT_PREPARING);
        end
        finish_test("measurement loading", errors_before);
    endtask

    // entered with a grow cycle just observed
    task automatic test_merge(input string label, input int odd_rounds);
        int errors_before;
        int cycles;
        int merge_cycles;
        errors_before = errors;
        // busy starts a cycle late, then flag lag and the exit cycle
        merge_cycles = `MAXIMUM_DELAY + busy_extra + 3;
        for (int i = 0; i <= odd_rounds; i++) begin
            check_stage(global_stage, STAGE_GROW);
            exp_iteration = exp_iteration + 8'd1;
            exp_cycles    = exp_cycles + 16'(1 + merge_cycles);
            @(posedge clk);
            check_stage(global_stage, STAGE_MERGE);
            cycles = 0;
            while (global_stage == STAGE_MERGE) begin
                cycles++;
                @(posedge clk);
            end
            check_count("merge length", cycles, merge_cycles);
        end
        check_stage(global_stage, STAGE_PEELING);
        exp_cycles = exp_cycles + 16'd1;
        finish_test(label, errors_before);
    endtask

    task automatic test_report(input string label);
        int errors_before;
        errors_before = errors;
        @(posedge clk);
        check_stage(global_stage, STAGE_RESULT_VALID);
        check_flag("ctrl_tx_valid", ctrl_tx_valid, 1'b1);
        report_expected                    = '0;
        report_expected.report.iteration   = exp_iteration;
        report_expected.report.cycle_count = exp_cycles;
        check_report(ctrl_tx_data, report_expected);
        repeat (2) begin
            @(posedge clk);
            check_stage(global_stage, STAGE_RESULT_VALID);
            check_flag("ctrl_tx_valid", ctrl_tx_valid, 1'b0);
        end
        @(posedge clk);
        check_stage(global_stage, STAGE_IDLE);
        finish_test(label, errors_before);
    endtask

    task automatic test_stream(input string label, input bit random_ready);
        logic [7:0]                   expected [0:STREAM_BYTES-1];
        logic [`CORRECTION_BYTES*8-1:0] padded;
        logic [7:0]                   held;
        bit                           waiting;
        int                           got;
        int                           base;
        int                           errors_before;
        errors_before = errors;
        base          = corr_count - `GRID_WIDTH_U;
        expected[0]   = report_expected.report.iteration;
        expected[1]   = report_expected.report.cycle_count[15:8];
        expected[2]   = report_expected.report.cycle_count[7:0];
        for (int w = 0; w < `GRID_WIDTH_U; w++) begin
            padded         = '0;
            padded[CW-1:0] = corr_words[base + w];
            for (int b = 0; b < `CORRECTION_BYTES; b++) begin   // low byte first
                expected[`HEADER_BYTES + w * `CORRECTION_BYTES + b] = padded[b*8 +: 8];
            end
        end
        got     = 0;
        waiting = 1'b0;
        output_ready <= random_ready ? 1'($urandom) : 1'b1;
        while (got < STREAM_BYTES) begin
            @(posedge clk);
            if (waiting) begin
                check_flag("output_valid", output_valid, 1'b1);
                check_byte("output_data held", output_data, held);
            end
            waiting = 1'b0;
            if (output_valid && output_ready) begin
                check_byte("output_data", output_data, expected[got]);
                got++;
            end else if (output_valid) begin
                held    = output_data;
                waiting = 1'b1;
            end
            output_ready <= random_ready ? 1'($urandom) : 1'b1;
        end
        output_ready <= 1'b0;
        finish_test(label, errors_before);
    endtask

    task automatic test_move_to_stage();
        int errors_before;
        errors_before = errors;
        odd_target <= 1;
        busy_extra <= 1;
        send_ctrl(MOVE_TO_STAGE);
        @(posedge clk);
        check_stage(global_stage, STAGE_GROW);
        finish_test("move to stage", errors_before);
    endtask

    initial begin
        void'($urandom(32'h527a_1ea6));
        reset         = 1'b1;
        input_data    = '0;
        input_valid   = 1'b0;
        output_ready  = 1'b0;
        ctrl_rx_data  = '0;
        ctrl_rx_valid = 1'b0;
        odd_target    = 0;
        busy_extra    = 0;
        test_reset();
        odd_target <= 2;
        busy_extra <= 3;
        test_load();
        test_merge("merge with two odd rounds", 2);
        test_report("report after loading");
        test_stream("byte stream, ready held", 1'b0);
        test_move_to_stage();
        test_merge("merge after move", 1);
        test_report("report after move");
        test_stream("byte stream, ready toggled", 1'b1);
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
